//--- flist.f
hdl/hazPkg.sv
hdl/pipeSlot.sv
hdl/instrDecode.sv
hdl/hazDet.sv
hdl/issueCtl.sv
hdl/hazTop.sv
test/hazTb_asserts.sv
test/hazTb.sv

//--- hdl/hazDet.sv
`timescale 1ns/10ps

module hazDet
    import hazPkg::*;
#(
    parameter int histDepth = 4
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        candValid,
    input  regIdxT      candRs,
    input  regIdxT      candRt,
    input  logic        readsRs,
    input  logic        readsRt,
    input  regIdxT      candRd,
    input  logic        writesReg,
    input  logic        isLoad,
    input  logic        memUse,
    input  logic [15:0] memAddr,
    input  logic        isCtrl,
    input  logic        isNop,
    input  logic        slotPush,
    input  logic        slotBubble,
    output logic        stall,
    output fwdT         fwd
);

    // Entry 0 is the slot issued just before the candidate
    logic [histDepth-1:0] hWr;
    logic [histDepth-1:0] hLoad;
    logic [histDepth-1:0] hMem;
    logic [histDepth-1:0] hCtrl;
    regIdxT               hDst  [histDepth];
    logic [15:0]          hAddr [histDepth];

    regIdxT srcIdx  [2];
    logic   srcUsed [2];
    logic   srcStall[2];
    logic   srcExEx [2];
    logic   srcMemEx[2];
    logic   memHit;
    logic   keep;

    assign srcIdx[0]  = candRs;
    assign srcIdx[1]  = candRt;
    assign srcUsed[0] = readsRs;
    assign srcUsed[1] = readsRt;

    // Same nearest-writer search for rs and rt
    for (genvar s = 0; s < 2; s++) begin : gSrc
        always_comb begin
            logic found;
            found       = 1'b0;
            srcStall[s] = 1'b0;
            srcExEx[s]  = 1'b0;
            srcMemEx[s] = 1'b0;
            for (int d = 0; d < histDepth; d++) begin
                if (!found && hWr[d] && hDst[d] == srcIdx[s]) begin
                    found = 1'b1;
                    if (d == 0) begin
                        // Load data is not ready for an EX to EX path
                        srcStall[s] = hLoad[d];
                        srcExEx[s]  = !hLoad[d];
                    end else if (d == 1) begin
                        srcMemEx[s] = 1'b1;
                    end else begin
                        srcStall[s] = 1'b1;
                    end
                end
            end
            if (!srcUsed[s]) begin
                srcStall[s] = 1'b0;
                srcExEx[s]  = 1'b0;
                srcMemEx[s] = 1'b0;
            end
        end
    end

    // Any in-flight access to the same address blocks a memory op
    always_comb begin
        memHit = 1'b0;
        for (int d = 0; d < histDepth; d++) begin
            if (hMem[d] && hAddr[d] == memAddr) begin
                memHit = 1'b1;
            end
        end
        memHit = memHit && memUse;
    end

    // A jump or branch one slot back always forces a bubble, even for a NOP
    assign stall = candValid &&
                   (hCtrl[0] || (!isNop && (srcStall[0] || srcStall[1] || memHit)));

    assign fwd = '{rsExEx:  srcExEx[0],
                   rsMemEx: srcMemEx[0],
                   rtExEx:  srcExEx[1],
                   rtMemEx: srcMemEx[1]};

    // Bubbles enter the history as inert slots
    assign keep = candValid && !slotBubble;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hWr   <= '0;
            hLoad <= '0;
            hMem  <= '0;
            hCtrl <= '0;
        end else if (slotPush) begin
            hWr   <= {hWr[histDepth-2:0], keep && writesReg};
            hLoad <= {hLoad[histDepth-2:0], keep && isLoad};
            hMem  <= {hMem[histDepth-2:0], keep && memUse};
            hCtrl <= {hCtrl[histDepth-2:0], keep && isCtrl};
        end
    end

    always_ff @(posedge clk) begin
        if (slotPush) begin
            hDst[0]  <= candRd;
            hAddr[0] <= memAddr;
            for (int d = 1; d < histDepth; d++) begin
                hDst[d]  <= hDst[d-1];
                hAddr[d] <= hAddr[d-1];
            end
        end
    end

endmodule

//--- hdl/hazPkg.sv
package hazPkg;

    // Instruction field positions
    localparam int opMsb  = 15;
    localparam int opLsb  = 11;
    localparam int rsMsb  = 10;
    localparam int rsLsb  = 8;
    localparam int rtMsb  = 7;
    localparam int rtLsb  = 5;
    localparam int rdMsb  = 4;
    localparam int rdLsb  = 2;
    localparam int immMsb = 4;
    localparam int immLsb = 0;
    localparam int immW   = immMsb - immLsb + 1;

    // Full opcodes
    localparam logic [4:0] opNop   = 5'b00001;
    localparam logic [4:0] opJr    = 5'b00111;
    localparam logic [4:0] opStore = 5'b10000;
    localparam logic [4:0] opLoad  = 5'b10001;

    // Class prefixes, matched against the upper opcode bits
    localparam logic [2:0] clsJump   = 3'b001;
    localparam logic [2:0] clsImm    = 3'b010;
    localparam logic [2:0] clsBranch = 3'b011;
    localparam logic [1:0] clsRegAlu = 2'b11;

    // NOP with all other fields zero, issued as a bubble
    localparam logic [15:0] bubbleWord = {opNop, 11'b0};

    typedef logic [2:0] regIdxT;

    // Forwarding select travelling with an issued instruction
    typedef struct packed {
        logic rsExEx;
        logic rsMemEx;
        logic rtExEx;
        logic rtMemEx;
    } fwdT;

    typedef struct packed {
        logic [15:0] instr;
        logic [15:0] rsData;
    } inItemT;

    typedef struct packed {
        logic [15:0] instr;
        fwdT         fwd;
    } outItemT;

endpackage

//--- hdl/hazTop.sv
`timescale 1ns/10ps

module hazTop
    import hazPkg::*;
#(
    parameter int histDepth = 4
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        inValid,
    output logic        inReady,
    input  logic [15:0] inInstr,
    input  logic [15:0] inRsData,
    output logic        outValid,
    input  logic        outReady,
    output logic [15:0] outInstr,
    output fwdT         outFwd
);

    // Candidate from decode
    logic        candValid;
    logic        candTake;
    logic [15:0] candInstr;
    regIdxT      candRs;
    regIdxT      candRt;
    regIdxT      candRd;
    logic        readsRs;
    logic        readsRt;
    logic        writesReg;
    logic        isLoad;
    logic        memUse;
    logic [15:0] memAddr;
    logic        isCtrl;
    logic        isNop;

    // Decision and history update
    logic        stall;
    fwdT         fwd;
    logic        slotPush;
    logic        slotBubble;

    instrDecode decode_i (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inInstr   (inInstr),
        .inRsData  (inRsData),
        .candValid (candValid),
        .candTake  (candTake),
        .candInstr (candInstr),
        .candRs    (candRs),
        .candRt    (candRt),
        .readsRs   (readsRs),
        .readsRt   (readsRt),
        .candRd    (candRd),
        .writesReg (writesReg),
        .isLoad    (isLoad),
        .memUse    (memUse),
        .memAddr   (memAddr),
        .isCtrl    (isCtrl),
        .isNop     (isNop)
    );

    hazDet #(.histDepth(histDepth)) det_i (
        .clk        (clk),
        .arstN      (arstN),
        .candValid  (candValid),
        .candRs     (candRs),
        .candRt     (candRt),
        .readsRs    (readsRs),
        .readsRt    (readsRt),
        .candRd     (candRd),
        .writesReg  (writesReg),
        .isLoad     (isLoad),
        .memUse     (memUse),
        .memAddr    (memAddr),
        .isCtrl     (isCtrl),
        .isNop      (isNop),
        .slotPush   (slotPush),
        .slotBubble (slotBubble),
        .stall      (stall),
        .fwd        (fwd)
    );

    issueCtl issue_i (
        .clk        (clk),
        .arstN      (arstN),
        .candValid  (candValid),
        .candInstr  (candInstr),
        .stall      (stall),
        .fwd        (fwd),
        .candTake   (candTake),
        .slotPush   (slotPush),
        .slotBubble (slotBubble),
        .outValid   (outValid),
        .outReady   (outReady),
        .outInstr   (outInstr),
        .outFwd     (outFwd)
    );

endmodule

//--- hdl/instrDecode.sv
`timescale 1ns/10ps

module instrDecode
    import hazPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        inValid,
    output logic        inReady,
    input  logic [15:0] inInstr,
    input  logic [15:0] inRsData,
    output logic        candValid,
    input  logic        candTake,
    output logic [15:0] candInstr,
    output regIdxT      candRs,
    output regIdxT      candRt,
    output logic        readsRs,
    output logic        readsRt,
    output regIdxT      candRd,
    output logic        writesReg,
    output logic        isLoad,
    output logic        memUse,
    output logic [15:0] memAddr,
    output logic        isCtrl,
    output logic        isNop
);

    inItemT      inItem;
    inItemT      cand;
    logic [4:0]  op;
    logic        isJump;
    logic        isBranch;
    logic        isImm;
    logic        isStore;
    logic        isRegAlu;
    logic [15:0] immExt;

    assign inItem = '{instr: inInstr, rsData: inRsData};

    pipeSlot #(.payloadT(inItemT)) inSlot_i (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inItem),
        .outValid (candValid),
        .outReady (candTake),
        .outData  (cand)
    );

    assign candInstr = cand.instr;
    assign op        = cand.instr[opMsb:opLsb];
    assign candRs    = cand.instr[rsMsb:rsLsb];
    assign candRt    = cand.instr[rtMsb:rtLsb];

    // Opcode classes
    assign isNop    = (op == opNop);
    assign isJump   = (op[4:2] == clsJump);
    assign isBranch = (op[4:2] == clsBranch);
    assign isImm    = (op[4:2] == clsImm);
    assign isStore  = (op == opStore);
    assign isLoad   = (op == opLoad);
    assign isRegAlu = (op[4:3] == clsRegAlu);

    // Only jr reads rs among the jumps
    assign readsRs   = (op == opJr) || isBranch || isImm || isStore || isLoad || isRegAlu;
    assign readsRt   = isStore || isRegAlu;
    assign writesReg = isImm || isLoad || isRegAlu;
    assign candRd    = isRegAlu ? regIdxT'(cand.instr[rdMsb:rdLsb]) : candRt;
    assign memUse    = isStore || isLoad;
    assign isCtrl    = isJump || isBranch;

    // Effective address is rs plus sign-extended immediate
    assign immExt  = {{(16 - immW){cand.instr[immMsb]}}, cand.instr[immMsb:immLsb]};
    assign memAddr = cand.rsData + immExt;

endmodule

//--- hdl/issueCtl.sv
`timescale 1ns/10ps

module issueCtl
    import hazPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        candValid,
    input  logic [15:0] candInstr,
    input  logic        stall,
    input  fwdT         fwd,
    output logic        candTake,
    output logic        slotPush,
    output logic        slotBubble,
    output logic        outValid,
    input  logic        outReady,
    output logic [15:0] outInstr,
    output fwdT         outFwd
);

    logic    sliceReady;
    outItemT pushItem;
    outItemT outItem;

    // A slot goes out only when there is a candidate to decide on
    assign slotPush   = candValid && sliceReady;
    assign slotBubble = stall;

    // The candidate is held while bubbles are issued in its place
    assign candTake = slotPush && !stall;

    always_comb begin
        if (stall) begin
            pushItem.instr = bubbleWord;
            pushItem.fwd   = '0;
        end else begin
            pushItem.instr = candInstr;
            pushItem.fwd   = fwd;
        end
    end

    pipeSlot #(.payloadT(outItemT)) outSlot_i (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (candValid),
        .inReady  (sliceReady),
        .inData   (pushItem),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outItem)
    );

    assign outInstr = outItem.instr;
    assign outFwd   = outItem.fwd;

endmodule

//--- hdl/pipeSlot.sv
`timescale 1ns/10ps

module pipeSlot #(
    parameter type payloadT = logic [15:0]
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    full;
    payloadT data;

    // Free when empty, or when the held item leaves this cycle
    assign inReady  = !full || outReady;
    assign outValid = full;
    assign outData  = data;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            full <= 1'b0;
        end else if (inReady) begin
            full <= inValid;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            data <= inData;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the hazard control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module hazTb \
    --Mdir obj_dir -o hazSim
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/hazSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "PASS: all tests" sim.log; then
    exit 0
fi
exit 1

//--- test/hazTb.sv
`timescale 1ns/10ps

module hazTb
    import hazPkg::*;
();

    localparam int histDepth = 4;
    localparam int nStim     = 21;
    localparam int nGrp      = 5;

    typedef struct {
        logic [15:0] instr;
        logic [15:0] rsData;
        int          grp;
    } stimT;

    logic        clk = 1'b0;
    logic        arstN;
    logic        inValid;
    logic        inReady;
    logic [15:0] inInstr;
    logic [15:0] inRsData;
    logic        outValid;
    logic        outReady;
    logic [15:0] outInstr;
    fwdT         outFwd;

    stimT        stim [nStim];
    string       grpName [nGrp] = '{"indep", "fwd", "loadUse", "memAddr", "ctrl"};
    int          grpLeft [nGrp];
    int          grpErr [nGrp];
    logic [15:0] expInstr [$];
    logic [3:0]  expFwd [$];
    int          expGrp [$];
    int          cycles = 0;
    int          limit = 0;

    hazTop #(.histDepth(histDepth)) dut_i (.*);

    always #20 clk = !clk;

    function automatic logic [15:0] rWord(logic [4:0] op, regIdxT rs, regIdxT rt, regIdxT rd);
        return {op, rs, rt, rd, 2'b00};
    endfunction

    function automatic logic [15:0] iWord(logic [4:0] op, regIdxT rs, regIdxT rt, logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] nextRand(logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Applies the issue rules to the table and yields one output slot per loop pass
    function automatic void buildExpected();
        logic        hWr [histDepth];
        logic        hLd [histDepth];
        logic        hMem [histDepth];
        logic        hCtl [histDepth];
        logic [2:0]  hDst [histDepth];
        logic [15:0] hAddr [histDepth];
        logic [15:0] w;
        logic [4:0]  op;
        logic [2:0]  src;
        logic [2:0]  dst;
        logic [15:0] addr;
        logic [3:0]  f;
        logic        rdRs, rdRt, wr, ld, mem, ctl, nop, used, found, stall, done;
        for (int d = 0; d < histDepth; d++) begin
            hWr[d] = 1'b0;
            hLd[d] = 1'b0;
            hMem[d] = 1'b0;
            hCtl[d] = 1'b0;
            hDst[d] = 3'd0;
            hAddr[d] = 16'd0;
        end
        for (int i = 0; i < nStim; i++) begin
            w    = stim[i].instr;
            op   = w[15:11];
            ld   = (op == 5'b10001);
            mem  = ld || (op == 5'b10000);
            ctl  = (op[4:2] == 3'b001) || (op[4:2] == 3'b011);
            nop  = (op == 5'b00001);
            rdRs = (op == 5'b00111) || (op[4:2] == 3'b011) || (op[4:2] == 3'b010) || mem
                   || (op[4:3] == 2'b11);
            rdRt = (op == 5'b10000) || (op[4:3] == 2'b11);
            wr   = (op[4:2] == 3'b010) || ld || (op[4:3] == 2'b11);
            dst  = (op[4:3] == 2'b11) ? w[4:2] : w[7:5];
            addr = stim[i].rsData + {{11{w[4]}}, w[4:0]};
            done = 1'b0;
            while (!done) begin
                stall = 1'b0;
                f = 4'b0000;
                for (int s = 0; s < 2; s++) begin
                    src = (s == 0) ? w[10:8] : w[7:5];
                    used = (s == 0) ? rdRs : rdRt;
                    found = 1'b0;
                    for (int d = 0; d < histDepth; d++) begin
                        if (used && !found && hWr[d] && hDst[d] == src) begin
                            found = 1'b1;
                            if (d == 0 && hLd[0]) stall = 1'b1;
                            else if (d == 0) f[3 - 2 * s] = 1'b1;
                            else if (d == 1) f[2 - 2 * s] = 1'b1;
                            else stall = 1'b1;
                        end
                    end
                end
                for (int d = 0; d < histDepth; d++) begin
                    if (mem && hMem[d] && hAddr[d] == addr) stall = 1'b1;
                end
                if (nop) stall = 1'b0;
                if (hCtl[0]) stall = 1'b1;
                for (int d = histDepth - 1; d > 0; d--) begin
                    hWr[d] = hWr[d-1];
                    hLd[d] = hLd[d-1];
                    hMem[d] = hMem[d-1];
                    hCtl[d] = hCtl[d-1];
                    hDst[d] = hDst[d-1];
                    hAddr[d] = hAddr[d-1];
                end
                hWr[0] = !stall && wr;
                hLd[0] = !stall && ld;
                hMem[0] = !stall && mem;
                hCtl[0] = !stall && ctl;
                hDst[0] = dst;
                hAddr[0] = addr;
                expInstr.push_back(stall ? bubbleWord : w);
                expFwd.push_back(stall ? 4'b0000 : f);
                expGrp.push_back(stim[i].grp);
                grpLeft[stim[i].grp]++;
                done = !stall;
            end
        end
    endfunction

    task automatic checkSlot(int i);
        int g;
        g = expGrp[i];
        assert (outInstr == expInstr[i] && outFwd == expFwd[i]) else begin
            $display("Error at %0t: slot %0d expected %h fwd %b, got %h fwd %b",
                     $time, i, expInstr[i], expFwd[i], outInstr, outFwd);
            grpErr[g]++;
        end
        grpLeft[g]--;
        if (grpLeft[g] == 0) begin
            $display("test %s: %s", grpName[g], (grpErr[g] == 0) ? "ok" : "failed");
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the DUT did not deliver all expected slots in %0d cycles", limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int          sIdx;
        int          oIdx;
        int          nPass;
        int          nFail;
        logic [31:0] lcg;
        arstN    = 1'b0;
        inValid  = 1'b0;
        inInstr  = 16'd0;
        inRsData = 16'd0;
        outReady = 1'b0;
        stim = '{
            '{rWord(5'b11000, 3'd2, 3'd3, 3'd1), 16'h0000, 0},
            '{iWord(5'b01000, 3'd5, 3'd4, 5'd1), 16'h0000, 0},
            '{bubbleWord, 16'h0000, 0},
            '{rWord(5'b11001, 3'd7, 3'd0, 3'd6), 16'h0000, 0},
            '{rWord(5'b11000, 3'd2, 3'd3, 3'd1), 16'h0000, 1},
            '{rWord(5'b11000, 3'd1, 3'd1, 3'd2), 16'h0000, 1},
            '{rWord(5'b11010, 3'd2, 3'd1, 3'd3), 16'h0000, 1},
            '{iWord(5'b10001, 3'd0, 3'd5, 5'd2), 16'h0040, 2},
            '{rWord(5'b11000, 3'd5, 3'd0, 3'd6), 16'h0000, 2},
            '{iWord(5'b01000, 3'd0, 3'd1, 5'd1), 16'h0000, 2},
            '{bubbleWord, 16'h0000, 2},
            '{bubbleWord, 16'h0000, 2},
            '{rWord(5'b11000, 3'd1, 3'd0, 3'd2), 16'h0000, 2},
            '{iWord(5'b10000, 3'd1, 3'd2, 5'd4), 16'h0010, 3},
            '{iWord(5'b10001, 3'd3, 3'd6, 5'b11100), 16'h0018, 3},
            '{iWord(5'b10000, 3'd4, 3'd5, 5'd1), 16'h0100, 3},
            '{iWord(5'b00100, 3'd0, 3'd0, 5'd3), 16'h0000, 4},
            '{iWord(5'b01100, 3'd1, 3'd0, 5'd2), 16'h0000, 4},
            '{iWord(5'b00111, 3'd2, 3'd0, 5'd0), 16'h0000, 4},
            '{bubbleWord, 16'h0000, 4},
            '{rWord(5'b11000, 3'd3, 3'd4, 3'd5), 16'h0000, 4}
        };
        buildExpected();
        limit = 8 * expInstr.size() + 50;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        sIdx = 0;
        oIdx = 0;
        lcg = 32'h20a8_9bc3;
        while (oIdx < expInstr.size()) begin
            @(negedge clk);
            lcg = nextRand(lcg);
            outReady = (lcg[31:16] % 16'd3) != 16'd0;
            inValid = (sIdx < nStim);
            if (sIdx < nStim) begin
                inInstr  = stim[sIdx].instr;
                inRsData = stim[sIdx].rsData;
            end
            // Handshakes settle well before the next rising edge
            #5;
            if (inValid && inReady) sIdx++;
            if (outValid && outReady) begin
                checkSlot(oIdx);
                oIdx++;
            end
        end
        nPass = 0;
        nFail = 0;
        for (int g = 0; g < nGrp; g++) begin
            if (grpErr[g] == 0 && grpLeft[g] == 0) nPass++;
            else nFail++;
        end
        $display("%0d tests passed, %0d tests failed", nPass, nFail);
        if (nFail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- test/hazTb_asserts.sv
`timescale 1ns/10ps

module hazAsserts
    import hazPkg::*;
(
    input logic        clk,
    input logic        arstN,
    input logic        outValid,
    input logic        outReady,
    input logic [15:0] outInstr
);

    logic afterCtrl;

    // Remembers whether the last transfer was a jump or branch
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            afterCtrl <= 1'b0;
        end else if (outValid && outReady) begin
            afterCtrl <= (outInstr[15:13] == clsJump) || (outInstr[15:13] == clsBranch);
        end
    end

    resetQuiet: assert property (@(posedge clk) !arstN |-> !outValid)
        else $error("outValid high during reset");

    holdStable: assert property (@(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outInstr))
        else $error("output changed under back-pressure");

    ctrlBubble: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady && afterCtrl |-> outInstr == bubbleWord)
        else $error("jump or branch not followed by a bubble");

endmodule

bind hazTop hazAsserts asserts_i (
    .clk      (clk),
    .arstN    (arstN),
    .outValid (outValid),
    .outReady (outReady),
    .outInstr (outInstr)
);
